/* hw/alu.sv */
// ====================================================================
// integer alu; shifts use b[4:0], branch compares only set br_taken
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire rv_pkg::alu_op_t              alu_op,
  input  wire logic [rv_pkg::xlen-1:0]      a,
  input  wire logic [rv_pkg::xlen-1:0]      b,
  output logic [rv_pkg::xlen-1:0]           result,
  output logic                              br_taken
);

  logic [4:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    result   = '0;
    br_taken = 1'b0;
    case (alu_op)
      rv_pkg::alu_add:  result = a + b;
      rv_pkg::alu_sub:  result = a - b;
      rv_pkg::alu_sll:  result = a << shamt;
      rv_pkg::alu_slt:  result = rv_pkg::xlen'(lt_signed);
      rv_pkg::alu_sltu: result = rv_pkg::xlen'(lt_unsigned);
      rv_pkg::alu_xor:  result = a ^ b;
      rv_pkg::alu_srl:  result = a >> shamt;
      rv_pkg::alu_sra:  result = $signed(a) >>> shamt;  // sign fills from the left
      rv_pkg::alu_or:   result = a | b;
      rv_pkg::alu_and:  result = a & b;
      rv_pkg::alu_beq:  br_taken = a == b;
      rv_pkg::alu_bne:  br_taken = a != b;
      rv_pkg::alu_blt:  br_taken = lt_signed;
      rv_pkg::alu_bge:  br_taken = !lt_signed;
      rv_pkg::alu_bltu: br_taken = lt_unsigned;
      default:          br_taken = !lt_unsigned;  // bgeu
    endcase
  end

endmodule

`default_nettype wire

/* hw/core_control.sv */
// ====================================================================
// sequencer: 4 byte fetches, execute, optional memory phase, write-back
// one instruction in flight; unknown opcodes retire as no-ops
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module core_control (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          mem_ready,
  input  wire logic [7:0]                    mem_rdata,
  input  wire logic                          br_taken,
  input  wire logic [rv_pkg::xlen-1:0]       alu_result,
  input  wire logic [rv_pkg::xlen-1:0]       imm,
  input  wire logic [2:0]                    funct3,
  input  wire logic                          alt_bit,
  input  wire logic                          lsu_busy,
  input  wire logic                          lsu_done,
  output rv_pkg::inst_t                      inst,
  output logic [rv_pkg::addr_width-1:0]      pc_addr,
  output logic                               fetch_valid,
  output rv_pkg::alu_op_t                    alu_op,
  output logic [1:0]                         a_sel,
  output logic                               b_sel,
  output logic                               rd_we,
  output logic [1:0]                         rd_data_sel,
  output logic                               lsu_start,
  output rv_pkg::size_t                      lsu_size,
  output logic                               lsu_unsigned,
  output logic                               lsu_store,
  output logic [rv_pkg::xlen-1:0]            pc_link
);

  typedef enum logic [2:0] {
    st_fetch0, st_fetch1, st_fetch2, st_fetch3, st_execute, st_mem, st_writeback
  } state_t;

  state_t state;
  state_t next_state;
  logic [rv_pkg::addr_width-1:0] pc;
  logic [rv_pkg::addr_width-1:0] pc_plus4;
  logic [rv_pkg::addr_width-1:0] pc_target;
  logic [1:0] inst_byte;
  logic inst_load;
  logic rd_write;
  logic [6:0] opcode;

  function automatic rv_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  return rv_pkg::alu_sll;
      3'b010:  return rv_pkg::alu_slt;
      3'b011:  return rv_pkg::alu_sltu;
      3'b100:  return rv_pkg::alu_xor;
      3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  function automatic rv_pkg::alu_op_t branch_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return rv_pkg::alu_beq;
      3'b001:  return rv_pkg::alu_bne;
      3'b100:  return rv_pkg::alu_blt;
      3'b101:  return rv_pkg::alu_bge;
      3'b110:  return rv_pkg::alu_bltu;
      default: return rv_pkg::alu_bgeu;  // 010 and 011 are reserved
    endcase
  endfunction

  assign opcode    = inst.r.opcode;
  assign inst_byte = state[2] ? 2'd0 : state[1:0];  // zero outside fetch, so pc_addr is pc
  assign inst_load = fetch_valid && mem_ready;
  assign pc_addr   = pc + rv_pkg::addr_width'(inst_byte);
  assign pc_plus4  = pc + rv_pkg::addr_width'(4);
  assign pc_link   = rv_pkg::xlen'(pc_plus4);

  always_comb begin
    next_state = state;
    case (state)
      st_fetch0, st_fetch1, st_fetch2, st_fetch3: begin
        if (inst_load) next_state = state_t'(state + 3'd1);  // fetch3 rolls into execute
      end
      st_execute: begin
        if (lsu_start) next_state = st_mem;
        else next_state = st_writeback;
      end
      st_mem: begin
        if (lsu_done) next_state = st_writeback;
      end
      default: next_state = st_fetch0;
    endcase
  end

  // operand and result selects follow the opcode, so the alu output
  // is already settled in execute and still valid in write-back
  always_comb begin
    alu_op      = rv_pkg::alu_add;
    a_sel       = rv_pkg::a_sel_rs1;
    b_sel       = rv_pkg::b_sel_imm;
    rd_data_sel = rv_pkg::rd_sel_alu;
    rd_write    = 1'b0;
    case (opcode)
      rv_pkg::opc_lui: begin
        a_sel    = rv_pkg::a_sel_zero;
        rd_write = 1'b1;
      end
      rv_pkg::opc_auipc: begin
        a_sel    = rv_pkg::a_sel_pc;
        rd_write = 1'b1;
      end
      rv_pkg::opc_jal, rv_pkg::opc_jalr: begin
        rd_data_sel = rv_pkg::rd_sel_link;  // alu gives the jalr target
        rd_write    = 1'b1;
      end
      rv_pkg::opc_branch: begin
        alu_op = branch_op(funct3);
        b_sel  = rv_pkg::b_sel_rs2;
      end
      rv_pkg::opc_load: begin
        rd_data_sel = rv_pkg::rd_sel_load;
        rd_write    = 1'b1;
      end
      rv_pkg::opc_op_imm: begin
        alu_op   = arith_op(funct3, alt_bit && funct3 == 3'b101);  // no subi
        rd_write = 1'b1;
      end
      rv_pkg::opc_op: begin
        alu_op   = arith_op(funct3, alt_bit);
        b_sel    = rv_pkg::b_sel_rs2;
        rd_write = 1'b1;
      end
      default: ;  // store, fence, system and unknown
    endcase
  end

  assign rd_we        = rd_write && state == st_writeback;
  assign lsu_start    = state == st_execute &&
                        (opcode == rv_pkg::opc_load || opcode == rv_pkg::opc_store);
  assign lsu_store    = opcode == rv_pkg::opc_store;
  assign lsu_size     = rv_pkg::size_t'(funct3[1:0]);
  assign lsu_unsigned = funct3[2];

  always_comb begin
    pc_target = pc_plus4;
    if (opcode == rv_pkg::opc_jal || (opcode == rv_pkg::opc_branch && br_taken)) begin
      pc_target = pc + imm[rv_pkg::addr_width-1:0];
    end else if (opcode == rv_pkg::opc_jalr) begin
      pc_target = {alu_result[rv_pkg::addr_width-1:1], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_fetch0;
      fetch_valid <= 1'b0;
      pc          <= rv_pkg::reset_pc;
    end else begin
      state       <= next_state;
      fetch_valid <= !next_state[2];  // request whenever the next state fetches
      if (state == st_writeback) pc <= pc_target;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_load) inst[{inst_byte, 3'b000} +: 8] <= mem_rdata;  // little-endian
  end

  a_fetch_hold: assert property (@(posedge clk) disable iff (reset)
    fetch_valid && !mem_ready |=> fetch_valid && $stable(pc_addr));

  // data transfers only run while the sequencer waits for them
  a_lsu_in_mem: assert property (@(posedge clk) disable iff (reset)
    lsu_busy |-> state == st_mem);

endmodule

`default_nettype wire

/* hw/imm_decode.sv */
// ====================================================================
// field extraction and sign-extended immediate for every format
// shift immediates keep funct7 above the 5 shamt bits the alu reads
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module imm_decode (
  input  wire rv_pkg::inst_t                     inst,
  output logic [rv_pkg::xlen-1:0]                imm,
  output logic [rv_pkg::reg_addr_width-1:0]      rs1_addr,
  output logic [rv_pkg::reg_addr_width-1:0]      rs2_addr,
  output logic [rv_pkg::reg_addr_width-1:0]      rd_addr,
  output logic [2:0]                             funct3,
  output logic                                   alt_bit
);

  assign rs1_addr = inst.r.rs1;
  assign rs2_addr = inst.r.rs2;
  assign rd_addr  = inst.r.rd;
  assign funct3   = inst.r.funct3;
  assign alt_bit  = inst.r.funct7[5];  // sub and sra

  always_comb begin
    case (inst.r.opcode)
      rv_pkg::opc_lui, rv_pkg::opc_auipc:
        imm = {inst.u.imm_31_12, 12'b0};
      rv_pkg::opc_jal:
        imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12, inst.j.imm_11,
               inst.j.imm_10_1, 1'b0};
      rv_pkg::opc_branch:
        imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11, inst.b.imm_10_5,
               inst.b.imm_4_1, 1'b0};
      rv_pkg::opc_store:
        imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
      default:
        imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};  // loads, jalr and op-imm
    endcase
  end

endmodule

`default_nettype wire

/* hw/load_store_unit.sv */
// ====================================================================
// moves 1, 2 or 4 bytes upward from base_addr, lowest byte first
// lsu_done pulses the cycle after the last accepted byte
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          lsu_start,
  input  wire rv_pkg::size_t                 lsu_size,
  input  wire logic                          lsu_unsigned,
  input  wire logic                          lsu_store,
  input  wire logic [rv_pkg::addr_width-1:0] base_addr,
  input  wire logic [rv_pkg::xlen-1:0]       store_data,
  input  wire logic                          mem_ready,
  input  wire logic [7:0]                    mem_rdata,
  output logic [rv_pkg::addr_width-1:0]      lsu_addr,
  output logic [7:0]                         lsu_wdata,
  output logic                               lsu_wren,
  output logic                               lsu_valid,
  output logic                               lsu_busy,
  output logic                               lsu_done,
  output logic [rv_pkg::xlen-1:0]            load_data
);

  logic [rv_pkg::addr_width-1:0] base_q;
  logic [rv_pkg::xlen-1:0] data_q;  // store word, or load bytes as they arrive
  rv_pkg::size_t size_q;
  logic unsigned_q;
  logic store_q;
  logic [1:0] count;
  logic [1:0] last;
  logic accept;

  assign last      = (size_q == rv_pkg::size_byte) ? 2'd0 :
                     (size_q == rv_pkg::size_half) ? 2'd1 : 2'd3;
  assign accept    = lsu_busy && mem_ready;
  assign lsu_valid = lsu_busy;
  assign lsu_wren  = lsu_busy && store_q;
  assign lsu_addr  = base_q + rv_pkg::addr_width'(count);
  assign lsu_wdata = data_q[{count, 3'b000} +: 8];

  always_ff @(posedge clk) begin
    if (reset) begin
      lsu_busy <= 1'b0;
      lsu_done <= 1'b0;
      count    <= 2'd0;
    end else begin
      lsu_done <= accept && count == last;
      if (lsu_start) begin
        lsu_busy <= 1'b1;
        count    <= 2'd0;
      end else if (accept) begin
        if (count == last) lsu_busy <= 1'b0;
        else count <= count + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_start) begin
      base_q     <= base_addr;
      data_q     <= store_data;
      size_q     <= lsu_size;
      unsigned_q <= lsu_unsigned;
      store_q    <= lsu_store;
    end else if (accept && !store_q) begin
      data_q[{count, 3'b000} +: 8] <= mem_rdata;
    end
  end

  always_comb begin
    case (size_q)
      rv_pkg::size_byte:
        load_data = {{(rv_pkg::xlen-8){!unsigned_q && data_q[7]}}, data_q[7:0]};
      rv_pkg::size_half:
        load_data = {{(rv_pkg::xlen-16){!unsigned_q && data_q[15]}}, data_q[15:0]};
      default:
        load_data = data_q;
    endcase
  end

  // the sequencer must wait for lsu_done before the next access
  a_no_restart: assert property (@(posedge clk) disable iff (reset)
    lsu_start |-> !lsu_busy);

endmodule

`default_nettype wire

/* hw/reg_file.sv */
// ====================================================================
// 32 x 32 register file, combinational reads, x0 reads as zero
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic                              clk,
  input  wire logic [rv_pkg::reg_addr_width-1:0] rs1_addr,
  input  wire logic [rv_pkg::reg_addr_width-1:0] rs2_addr,
  input  wire logic [rv_pkg::reg_addr_width-1:0] rd_addr,
  input  wire logic                              rd_we,
  input  wire logic [rv_pkg::xlen-1:0]           rd_data,
  output logic [rv_pkg::xlen-1:0]                rs1_data,
  output logic [rv_pkg::xlen-1:0]                rs2_data
);

  logic [rv_pkg::xlen-1:0] regs [0:31];

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (rd_we && rd_addr != '0) begin  // x0 writes dropped
      regs[rd_addr] <= rd_data;
    end
  end

endmodule

`default_nettype wire

/* hw/rv_core.sv */
// ====================================================================
// RV32I core top, one byte-wide valid/ready memory port
// port belongs to the load/store unit while it is busy, else to fetch
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  wire logic                          clk,
  input  wire logic                          reset,
  output logic [rv_pkg::addr_width-1:0]      mem_addr,
  output logic [7:0]                         mem_wdata,
  output logic                               mem_wren,
  output logic                               mem_valid,
  input  wire logic                          mem_ready,
  input  wire logic [7:0]                    mem_rdata
);

  rv_pkg::inst_t inst;
  rv_pkg::alu_op_t alu_op;
  rv_pkg::size_t lsu_size;
  logic [rv_pkg::addr_width-1:0] pc_addr;
  logic [rv_pkg::addr_width-1:0] lsu_addr;
  logic [rv_pkg::xlen-1:0] imm;
  logic [rv_pkg::xlen-1:0] alu_a;
  logic [rv_pkg::xlen-1:0] alu_b;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] rd_data;
  logic [rv_pkg::xlen-1:0] load_data;
  logic [rv_pkg::xlen-1:0] pc_link;
  logic [rv_pkg::reg_addr_width-1:0] rs1_addr;
  logic [rv_pkg::reg_addr_width-1:0] rs2_addr;
  logic [rv_pkg::reg_addr_width-1:0] rd_addr;
  logic [2:0] funct3;
  logic [1:0] a_sel;
  logic [1:0] rd_data_sel;
  logic [7:0] lsu_wdata;
  logic alt_bit;
  logic b_sel;
  logic br_taken;
  logic rd_we;
  logic fetch_valid;
  logic lsu_start;
  logic lsu_unsigned;
  logic lsu_store;
  logic lsu_busy;
  logic lsu_done;
  logic lsu_valid;
  logic lsu_wren;

  assign mem_valid = lsu_busy ? lsu_valid : fetch_valid;
  assign mem_addr  = lsu_busy ? lsu_addr : pc_addr;
  assign mem_wren  = lsu_busy && lsu_wren;
  assign mem_wdata = lsu_wdata;

  assign alu_a = (a_sel == rv_pkg::a_sel_pc)   ? rv_pkg::xlen'(pc_addr) :  // pc outside fetch
                 (a_sel == rv_pkg::a_sel_zero) ? {rv_pkg::xlen{1'b0}} : rs1_data;
  assign alu_b = (b_sel == rv_pkg::b_sel_imm) ? imm : rs2_data;
  assign rd_data = (rd_data_sel == rv_pkg::rd_sel_load) ? load_data :
                   (rd_data_sel == rv_pkg::rd_sel_link) ? pc_link : alu_result;

  core_control u_control (
    .clk(clk), .reset(reset), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
    .br_taken(br_taken), .alu_result(alu_result), .imm(imm), .funct3(funct3),
    .alt_bit(alt_bit), .lsu_busy(lsu_busy), .lsu_done(lsu_done), .inst(inst),
    .pc_addr(pc_addr), .fetch_valid(fetch_valid), .alu_op(alu_op), .a_sel(a_sel),
    .b_sel(b_sel), .rd_we(rd_we), .rd_data_sel(rd_data_sel), .lsu_start(lsu_start),
    .lsu_size(lsu_size), .lsu_unsigned(lsu_unsigned), .lsu_store(lsu_store),
    .pc_link(pc_link)
  );

  reg_file u_regs (
    .clk(clk), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
    .rd_we(rd_we), .rd_data(rd_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  imm_decode u_decode (
    .inst(inst), .imm(imm), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rd_addr(rd_addr), .funct3(funct3), .alt_bit(alt_bit)
  );

  alu u_alu (
    .alu_op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .br_taken(br_taken)
  );

  load_store_unit u_lsu (
    .clk(clk), .reset(reset), .lsu_start(lsu_start), .lsu_size(lsu_size),
    .lsu_unsigned(lsu_unsigned), .lsu_store(lsu_store),
    .base_addr(alu_result[rv_pkg::addr_width-1:0]), .store_data(rs2_data),
    .mem_ready(mem_ready), .mem_rdata(mem_rdata), .lsu_addr(lsu_addr),
    .lsu_wdata(lsu_wdata), .lsu_wren(lsu_wren), .lsu_valid(lsu_valid),
    .lsu_busy(lsu_busy), .lsu_done(lsu_done), .load_data(load_data)
  );

endmodule

`default_nettype wire

/* hw/rv_pkg.sv */
// ====================================================================
// shared widths and encodings of the byte-port RV32I core
// addresses are 16 bits wide, so pc and data addresses wrap there
// ====================================================================
`default_nettype none

package rv_pkg;

  localparam int xlen           = 32;
  localparam int addr_width     = 16;
  localparam int reg_addr_width = 5;
  localparam logic [addr_width-1:0] reset_pc = '0;

  // major opcodes, everything else executes as a no-op
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;

  localparam logic [1:0] a_sel_rs1   = 2'd0;
  localparam logic [1:0] a_sel_pc    = 2'd1;
  localparam logic [1:0] a_sel_zero  = 2'd2;  // lui adds its immediate to zero
  localparam logic       b_sel_rs2   = 1'b0;
  localparam logic       b_sel_imm   = 1'b1;
  localparam logic [1:0] rd_sel_alu  = 2'd0;
  localparam logic [1:0] rd_sel_load = 2'd1;
  localparam logic [1:0] rd_sel_link = 2'd2;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
  } alu_op_t;

  typedef enum logic [1:0] {
    size_byte, size_half, size_word
  } size_t;  // matches funct3[1:0] of loads and stores

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_t;

endpackage

`default_nettype wire

/* project.f */
hw/rv_pkg.sv
hw/reg_file.sv
hw/imm_decode.sv
hw/alu.sv
hw/load_store_unit.sv
hw/core_control.sv
hw/rv_core.sv
verification/tb_memory.sv
verification/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_core -f project.f
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vtb_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
echo "pass message not found"
exit 1

/* verification/tb_memory.sv */
// ====================================================================
// 64 KiB byte memory with random ready and a preloaded test program
// results go to 0x0400..0x04ff, the marker byte goes to 0xfffc
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_memory (
  input  wire logic        clk,
  input  wire logic [15:0] mem_addr,
  input  wire logic [7:0]  mem_wdata,
  input  wire logic        mem_wren,
  input  wire logic        mem_valid,
  output logic             mem_ready,
  output logic [7:0]       mem_rdata,
  output logic [15:0]      prog_words,
  output logic [15:0]      jal_pc,
  output logic [15:0]      auipc_pc,
  output logic [15:0]      far_pc
);

  logic [7:0] mem [0:65535];
  logic [15:0] pc;
  integer seed;
  integer r;

  assign mem_rdata = mem[mem_addr];  // read data valid in the accepting cycle

  always @(posedge clk) begin
    r = $random(seed);
    mem_ready <= ((r % 100 + 100) % 100) < 70;  // about 70 percent ready
    if (mem_valid && mem_ready && mem_wren) mem[mem_addr] <= mem_wdata;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::opc_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::opc_branch};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::opc_jal};
  endfunction

  task automatic emit(input logic [31:0] w);
    mem[pc]      = w[7:0];  // little-endian
    mem[pc + 1]  = w[15:8];
    mem[pc + 2]  = w[23:16];
    mem[pc + 3]  = w[31:24];
    pc = pc + 16'd4;
  endtask

  // result in x4, stored as a word at x10 + off
  task automatic op_store(input logic [31:0] w, input logic [11:0] off);
    emit(w);
    emit(s_type(off, 5'd4, 5'd10, 3'b010));
  endtask

  task automatic emit_poison();
    emit(s_type(12'd124, 5'd9, 5'd10, 3'b010));
  endtask

  initial begin
    seed = 51;
    mem_ready = 1'b0;
    for (int a = 0; a < 65536; a++) mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h3c;
    pc = 16'd0;
    emit(u_type(20'h12345, 5'd1, rv_pkg::opc_lui));
    emit(i_type(12'h678, 5'd1, 3'b000, 5'd1, rv_pkg::opc_op_imm));  // x1 = 0x12345678
    emit(i_type(12'hff9, 5'd0, 3'b000, 5'd2, rv_pkg::opc_op_imm));  // x2 = -7
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd3, rv_pkg::opc_op_imm));
    emit(i_type(12'h400, 5'd0, 3'b000, 5'd10, rv_pkg::opc_op_imm));  // result base
    emit(i_type(12'h666, 5'd0, 3'b000, 5'd9, rv_pkg::opc_op_imm));  // poison
    op_store(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 12'd0);
    op_store(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 12'd4);
    op_store(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd4), 12'd8);
    op_store(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd4), 12'd12);
    op_store(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd4), 12'd16);
    op_store(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd4), 12'd20);
    op_store(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd4), 12'd24);
    op_store(r_type(7'h00, 5'd3, 5'd1, 3'b001, 5'd4), 12'd28);
    op_store(r_type(7'h00, 5'd3, 5'd2, 3'b101, 5'd4), 12'd32);
    op_store(r_type(7'h20, 5'd3, 5'd2, 3'b101, 5'd4), 12'd36);
    op_store(i_type(12'hf9c, 5'd1, 3'b000, 5'd4, rv_pkg::opc_op_imm), 12'd40);
    op_store(i_type(12'hffb, 5'd2, 3'b010, 5'd4, rv_pkg::opc_op_imm), 12'd44);
    op_store(i_type(12'd5, 5'd1, 3'b011, 5'd4, rv_pkg::opc_op_imm), 12'd48);
    op_store(i_type(12'h0f0, 5'd1, 3'b100, 5'd4, rv_pkg::opc_op_imm), 12'd52);
    op_store(i_type(12'h123, 5'd2, 3'b110, 5'd4, rv_pkg::opc_op_imm), 12'd56);
    op_store(i_type(12'h7ff, 5'd1, 3'b111, 5'd4, rv_pkg::opc_op_imm), 12'd60);
    op_store(i_type(12'd4, 5'd1, 3'b001, 5'd4, rv_pkg::opc_op_imm), 12'd64);
    op_store(i_type(12'd28, 5'd2, 3'b101, 5'd4, rv_pkg::opc_op_imm), 12'd68);
    op_store(i_type(12'h402, 5'd2, 3'b101, 5'd4, rv_pkg::opc_op_imm), 12'd72);  // srai 2
    emit(s_type(12'd80, 5'd1, 5'd10, 3'b000));
    emit(s_type(12'd84, 5'd1, 5'd10, 3'b001));
    emit(s_type(12'd88, 5'd1, 5'd10, 3'b010));
    emit(i_type(12'h080, 5'd0, 3'b000, 5'd6, rv_pkg::opc_op_imm));
    emit(s_type(12'd96, 5'd6, 5'd10, 3'b000));
    emit(u_type(20'h00008, 5'd7, rv_pkg::opc_lui));
    emit(i_type(12'd1, 5'd7, 3'b000, 5'd7, rv_pkg::opc_op_imm));  // x7 = 0x8001
    emit(s_type(12'd100, 5'd7, 5'd10, 3'b001));
    op_store(i_type(12'd96, 5'd10, 3'b000, 5'd4, rv_pkg::opc_load), 12'd104);
    op_store(i_type(12'd96, 5'd10, 3'b100, 5'd4, rv_pkg::opc_load), 12'd108);
    op_store(i_type(12'd100, 5'd10, 3'b001, 5'd4, rv_pkg::opc_load), 12'd112);
    op_store(i_type(12'd100, 5'd10, 3'b101, 5'd4, rv_pkg::opc_load), 12'd116);
    op_store(i_type(12'd88, 5'd10, 3'b010, 5'd4, rv_pkg::opc_load), 12'd120);
    emit(b_type(13'd8, 5'd3, 5'd3, 3'b000));  // each taken branch skips the poison
    emit_poison();
    emit(b_type(13'd8, 5'd1, 5'd2, 3'b100));
    emit_poison();
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b110));
    emit_poison();
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b101));
    emit_poison();
    emit(b_type(13'd8, 5'd1, 5'd2, 3'b111));
    emit_poison();
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));
    emit_poison();
    emit(b_type(13'd8, 5'd3, 5'd3, 3'b001));  // not taken
    emit(s_type(12'd128, 5'd3, 5'd10, 3'b010));
    jal_pc = pc;
    emit(j_type(21'd8, 5'd11));
    emit_poison();
    emit(s_type(12'd132, 5'd11, 5'd10, 3'b010));
    auipc_pc = pc;
    emit(u_type(20'h0, 5'd12, rv_pkg::opc_auipc));
    emit(s_type(12'd136, 5'd12, 5'd10, 3'b010));
    emit(i_type(12'd16, 5'd12, 3'b000, 5'd13, rv_pkg::opc_jalr));  // lands 16 past auipc
    emit_poison();
    emit(s_type(12'd140, 5'd13, 5'd10, 3'b010));
    far_pc = pc;
    emit(u_type(20'h1, 5'd14, rv_pkg::opc_auipc));
    emit(s_type(12'd144, 5'd14, 5'd10, 3'b010));
    emit(i_type(12'hffc, 5'd0, 3'b000, 5'd15, rv_pkg::opc_op_imm));
    emit(i_type(12'h0a5, 5'd0, 3'b000, 5'd16, rv_pkg::opc_op_imm));
    emit(s_type(12'd0, 5'd16, 5'd15, 3'b000));  // marker byte
    emit(j_type(21'd0, 5'd0));
    prog_words = pc >> 2;
  end

endmodule

`default_nettype wire

/* verification/tb_rv_core.sv */
// ====================================================================
// testbench top: every accepted write is checked against a table
// built from the program operands; the run ends on the 0xfffc marker
// ====================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic [15:0] mem_addr;
  logic [7:0] mem_wdata;
  logic [7:0] mem_rdata;
  logic mem_wren;
  logic mem_valid;
  logic mem_ready;
  logic [15:0] prog_words;
  logic [15:0] jal_pc;
  logic [15:0] auipc_pc;
  logic [15:0] far_pc;
  logic [7:0] exp_byte [0:255];
  logic exp_set [0:255];
  int wr_count [0:255];
  int value_errors = 0;
  int other_errors = 0;
  logic done = 1'b0;
  logic wr_fire;
  logic in_window;
  logic write_ok;
  logic [7:0] idx;

  always #5 clk = ~clk;

  rv_core uut (
    .clk(clk), .reset(reset), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_wren(mem_wren), .mem_valid(mem_valid), .mem_ready(mem_ready),
    .mem_rdata(mem_rdata)
  );

  tb_memory u_mem (
    .clk(clk), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wren(mem_wren),
    .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
    .prog_words(prog_words), .jal_pc(jal_pc), .auipc_pc(auipc_pc), .far_pc(far_pc)
  );

  assign wr_fire   = mem_valid && mem_ready && mem_wren;
  assign in_window = mem_addr[15:8] == 8'h04;  // result area 0x0400..0x04ff
  assign idx       = mem_addr[7:0];
  assign write_ok  = (mem_addr == 16'hfffc) ? mem_wdata == 8'ha5 :
                     in_window && exp_set[idx] && exp_byte[idx] == mem_wdata;

  a_write_ok: assert property (@(posedge clk) disable iff (reset) wr_fire |-> write_ok)
    else begin
      value_errors++;
      $display("** Error at %0t: unexpected byte %02h written to %04h", $time,
               $sampled(mem_wdata), $sampled(mem_addr));
    end

  a_port_hold: assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wren) &&
    (!mem_wren || $stable(mem_wdata)))
    else begin
      other_errors++;
      $display("memory request changed while stalled at %0t", $time);
    end

  always @(posedge clk) begin
    if (!reset && wr_fire && in_window) wr_count[idx] <= wr_count[idx] + 1;
    if (!reset && wr_fire && mem_addr == 16'hfffc) done <= 1'b1;
  end

  task automatic expect_bytes(input int off, input logic [31:0] v, input int n);
    for (int i = 0; i < n; i++) begin
      exp_set[off + i]  = 1'b1;
      exp_byte[off + i] = v[8*i +: 8];
    end
  endtask

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] s;
    a = 32'h12345678;
    b = 32'hfffffff9;  // -7
    s = 32'd5;
    for (int i = 0; i < 256; i++) begin
      exp_set[i]  = 1'b0;
      exp_byte[i] = 8'h00;
      wr_count[i] = 0;
    end
    expect_bytes(0, a + b, 4);
    expect_bytes(4, a - b, 4);
    expect_bytes(8, {31'd0, $signed(b) < $signed(a)}, 4);
    expect_bytes(12, {31'd0, b < a}, 4);
    expect_bytes(16, a ^ b, 4);
    expect_bytes(20, a | b, 4);
    expect_bytes(24, a & b, 4);
    expect_bytes(28, a << s[4:0], 4);
    expect_bytes(32, b >> s[4:0], 4);
    expect_bytes(36, $signed(b) >>> s[4:0], 4);
    expect_bytes(40, a + 32'hffffff9c, 4);  // -100
    expect_bytes(44, {31'd0, $signed(b) < -32'sd5}, 4);
    expect_bytes(48, {31'd0, a < 32'd5}, 4);
    expect_bytes(52, a ^ 32'h0f0, 4);
    expect_bytes(56, b | 32'h123, 4);
    expect_bytes(60, a & 32'h7ff, 4);
    expect_bytes(64, a << 4, 4);
    expect_bytes(68, b >> 28, 4);
    expect_bytes(72, $signed(b) >>> 2, 4);
    expect_bytes(80, a, 1);
    expect_bytes(84, a, 2);
    expect_bytes(88, a, 4);
    expect_bytes(96, 32'h80, 1);
    expect_bytes(100, 32'h8001, 2);
    expect_bytes(104, {{24{1'b1}}, 8'h80}, 4);  // lb sign-extends
    expect_bytes(108, 32'h80, 4);
    expect_bytes(112, {{16{1'b1}}, 16'h8001}, 4);
    expect_bytes(116, 32'h8001, 4);
    expect_bytes(120, a, 4);
    expect_bytes(128, s, 4);
    expect_bytes(132, {16'd0, jal_pc} + 32'd4, 4);
    expect_bytes(136, {16'd0, auipc_pc}, 4);
    expect_bytes(140, {16'd0, auipc_pc} + 32'd12, 4);  // jalr link
    expect_bytes(144, {16'd0, far_pc} + 32'h1000, 4);
  endtask

  initial begin
    repeat (3) @(posedge clk);
    build_table();
    reset <= 1'b0;
    wait (done);
    repeat (2) @(posedge clk);
    for (int i = 0; i < 256; i++) begin
      if (exp_set[i] && wr_count[i] != 1) begin
        other_errors++;
        $display("result byte at %04h written %0d times instead of once", 16'h0400 + i,
                 wr_count[i]);
      end
    end
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog, 40 cycles per instruction with a factor 3 for stalls
  initial begin
    wait (!reset);
    repeat (40 * int'(prog_words) * 3) @(posedge clk);
    $display("timeout: the program never wrote its marker byte");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
